// File: dc302_core.f
+incdir+tests
common/dc302_data_pkg.sv
common/dc302_uop_pkg.sv
regfile/dc302_regfile.sv
alu/dc302_alu.sv
verilog/dc302_branch_eval.sv
verilog/dc302_commit.sv
verilog/dc302_top.sv
tests/tb_dc302.sv

// File: Makefile
# Verilator lint and simulation of the DC302 data path

TOP = tb_dc302
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f dc302_core.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f dc302_core.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tests/tb_dc302_model.svh
/* reference model: registers with stack banking and IR fields,
   PSW, ALU results and flags, microbranch and PDP branch tables */

word_t m_regs [16];
word_t m_ir;

task automatic model_reset();
   for (int i = 0; i < 16; i++)
      m_regs[i] = 16'hFFFF;
   m_regs[8] = 16'hF8FF;                             // user mode, flags set
   m_ir      = 16'h0000;
endtask

// physical register behind a select, -1 when nothing is addressed
function automatic int model_phys(input logic [3:0] sel);
   case (sel)
      4'd12: return int'(m_ir[8:6]);
      4'd13: return int'(m_ir[2:0]);
      4'd6:
         case (m_regs[8][15:14])
            2'b00:   return 6;
            2'b01:   return 12;
            2'b11:   return 13;
            default: return -1;                      // invalid mode
         endcase
      default: return int'(sel);
   endcase
endfunction

function automatic word_t model_read(input logic [3:0] sel);
   int p;
   p = model_phys(sel);
   return (p < 0) ? 16'h0000 : m_regs[p];
endfunction

function automatic logic micro_branch(input logic [2:0] cond, input word_t p);
   case (cond)
      3'd0:    return p[3];
      3'd1:    return p[2];
      3'd2:    return p[0];
      3'd3:    return p[1];
      3'd4:    return p[3] ^ p[1];
      3'd5:    return p[2] | (p[3] ^ p[1]);
      3'd6:    return p[0] | p[2];
      default: return p[15:14] == 2'b00;             // kernel
   endcase
endfunction

function automatic logic pdp_branch(input word_t p, input word_t irv);
   logic t;
   case ({irv[15], irv[10], irv[9]})
      3'b000:  t = 1'b1;
      3'b001:  t = p[2];
      3'b010:  t = p[3] ^ p[1];
      3'b011:  t = p[2] | (p[3] ^ p[1]);
      3'b100:  t = p[3];
      3'b101:  t = p[0] | p[2];
      3'b110:  t = p[1];
      default: t = p[0];
   endcase
   return irv[8] ? t : ~t;
endfunction

// predicts one microinstruction and updates the model state
task automatic model_exec(input uop_t u, output word_t data, output flags_t flg,
                          output logic br);
   op_e         op;
   logic        bf;
   logic [3:0]  a_sel;
   word_t       a, b, r, psw;
   logic [8:0]  s9;
   logic [16:0] s17;
   logic        n, z, v, c, wr;
   int          hb, p;
   op    = op_e'(u[15:12]);
   bf    = u[11];
   a_sel = u[7:4];
   hb    = bf ? 7 : 15;
   psw   = m_regs[8];
   a     = model_read(a_sel);
   b     = (op == OP_LDI) ? {9'b0, u[10:8], u[3:0]} : model_read(u[3:0]);
   v     = 1'b0;
   c     = psw[0];                                   // carry kept by default
   r     = b;
   wr    = 1'b1;
   br    = 1'b0;
   case (op)
      OP_ADD:
      begin
         r   = a + b;
         s9  = {1'b0, a[7:0]} + {1'b0, b[7:0]};
         s17 = {1'b0, a} + {1'b0, b};
         c   = bf ? s9[8] : s17[16];
         v   = (a[hb] == b[hb]) && (r[hb] != a[hb]);
      end
      OP_SUB:
      begin
         r = a - b;
         c = bf ? (a[7:0] < b[7:0]) : (a < b);       // borrow
         v = (a[hb] != b[hb]) && (r[hb] != a[hb]);
      end
      OP_AND: r = a & b;
      OP_BIC: r = a & ~b;
      OP_BIS: r = a | b;
      OP_XOR: r = a ^ b;
      OP_ASR:
      begin
         r = bf ? {b[15:8], b[7], b[7:1]} : {b[15], b[15:1]};
         c = b[0];
      end
      OP_MOV, OP_LDI: r = b;
      default: wr = 1'b0;
   endcase
   if (wr)
   begin
      if (bf)
         r = {a[15:8], r[7:0]};                      // high byte of A kept
      n = r[hb];
      z = bf ? (r[7:0] == 8'd0) : (r == 16'd0);
      if (op == OP_ASR)
         v = n ^ c;
      if (a_sel == 4'd8)
         m_regs[8] = r & 16'hF8FF;
      else
      begin
         p = model_phys(a_sel);
         if (p >= 0)
            m_regs[p] = r;
         m_regs[8] = {psw[15:4], n, z, v, c} & 16'hF8FF;
      end
      data = r;
   end
   else
   begin
      data = a;
      if (op == OP_LDIR)
         m_ir = a;
      if (op == OP_BRA)
         br = pdp_branch(psw, m_ir);
      if (op == OP_MBR)
         br = micro_branch(u[10:8], psw);
   end
   flg = m_regs[8][3:0];
endtask

// File: tests/tb_dc302.sv
/* testbench for the DC302 data path: clock, reset, directed and
   random microinstruction tests, result checks and watchdog */
`timescale 1ns/1ps

module tb_dc302
   import dc302_data_pkg::*;
   import dc302_uop_pkg::*;
();

   localparam int CLK_NS       = 4;
   localparam int RESET_CYCLES = 16;
   localparam int LOAD_OPS     = 14;                 // ops spent by load_word
   localparam int N_ALU        = 300;
   localparam int N_IR         = 16;
   localparam int N_BR         = 24;
   localparam int N_STALL      = 100;
   localparam int TOTAL_OPS    = 15 + (12 + N_ALU) + 8 * (LOAD_OPS + 3)
                               + N_IR * (LOAD_OPS + 7) + N_BR * (2 * LOAD_OPS + 11)
                               + N_STALL;
   localparam int WATCHDOG_NS  = (TOTAL_OPS * 20 + RESET_CYCLES + 10) * CLK_NS;

   logic   clk;
   logic   rst;
   uop_t   uop;
   logic   uop_valid;
   logic   uop_ready;
   word_t  res_data;
   flags_t res_flags;
   logic   res_branch;
   logic   res_valid;
   logic   res_ready;

   int errors;
   int checks;
   int tests_run;

   `include "tb_dc302_model.svh"

   dc302_top uut (
      .clk        (clk),
      .rst        (rst),
      .uop        (uop),
      .uop_valid  (uop_valid),
      .uop_ready  (uop_ready),
      .res_data   (res_data),
      .res_flags  (res_flags),
      .res_branch (res_branch),
      .res_valid  (res_valid),
      .res_ready  (res_ready)
   );

   always #(CLK_NS / 2) clk = ~clk;

   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flags(input string name, input flags_t got, input flags_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("t=%0t %s", $time, what);
   endtask

   task automatic end_test(input string name, input int err_before);
      tests_run++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
   endtask

   function automatic uop_t alu_uop(input op_e op, input logic bf, input reg_sel_t a,
                                    input reg_sel_t b);
      return {op, bf, 3'b000, a, b};
   endfunction

   function automatic uop_t ldi_uop(input reg_sel_t a, input logic [6:0] imm);
      return {OP_LDI, 1'b0, imm[6:4], a, imm[3:0]};
   endfunction

   // issue one uop at a falling edge, check the result, hold it for stall cycles
   task automatic run_uop(input uop_t u, input int stall, output word_t got);
      word_t  exp_data;
      flags_t exp_flags;
      logic   exp_br;
      int     n;
      model_exec(u, exp_data, exp_flags, exp_br);
      uop       = u;
      uop_valid = 1'b1;
      res_ready = (stall == 0);
      n         = 0;
      while (!uop_ready && n < 20)
      begin
         @(negedge clk);
         n++;
      end
      if (!uop_ready)
         report_failure("uop_ready never rose, uop not accepted");
      @(posedge clk);                                // accepted here
      @(negedge clk);
      uop_valid = 1'b0;
      n         = 1;
      while (!res_valid && n < 20)
      begin
         @(negedge clk);
         n++;
      end
      got = res_data;
      if (!res_valid)
         report_failure("no result within 20 cycles of acceptance");
      else
      begin
         if (n != 2)
            report_failure($sformatf("result came %0d cycles after acceptance, not 2", n));
         check_word("res_data", res_data, exp_data);
         check_flags("res_flags", res_flags, exp_flags);
         check_bit("res_branch", res_branch, exp_br);
         for (int i = 0; i < stall; i++)
         begin
            @(negedge clk);
            check_bit("res_valid", res_valid, 1'b1);
            check_word("res_data", res_data, got);   // must hold under back-pressure
            check_bit("uop_ready", uop_ready, 1'b0);
         end
         res_ready = 1'b1;
         @(negedge clk);
         check_bit("res_valid", res_valid, 1'b0);
         check_bit("uop_ready", uop_ready, 1'b1);
      end
   endtask

   // builds a full word in dst from 7-bit immediates and doublings
   task automatic load_word(input reg_sel_t dst, input reg_sel_t tmp, input word_t val);
      word_t got;
      run_uop(ldi_uop(dst, val[15:9]), 0, got);
      repeat (7) run_uop(alu_uop(OP_ADD, 1'b0, dst, dst), 0, got);
      run_uop(ldi_uop(tmp, val[8:2]), 0, got);
      run_uop(alu_uop(OP_BIS, 1'b0, dst, tmp), 0, got);
      repeat (2) run_uop(alu_uop(OP_ADD, 1'b0, dst, dst), 0, got);
      run_uop(ldi_uop(tmp, {5'b0, val[1:0]}), 0, got);
      run_uop(alu_uop(OP_BIS, 1'b0, dst, tmp), 0, got);
   endtask

   task automatic set_psw(input word_t val);
      word_t got;
      load_word(4'd15, 4'd14, val);
      run_uop(alu_uop(OP_MOV, 1'b0, PSW_REG, 4'd15), 0, got);
   endtask

   task automatic random_op(input int stall);
      reg_sel_t a;
      reg_sel_t b;
      uop_t     u;
      word_t    got;
      a = reg_sel_t'($urandom % 16);
      b = reg_sel_t'($urandom % 16);
      if (a == PSW_REG)
         a = 4'd9;                                   // keep flags observable
      if ($urandom % 8 == 0)
         u = ldi_uop(a, 7'($urandom));
      else
         u = alu_uop(op_e'(4'($urandom % 8)), 1'($urandom), a, b);
      run_uop(u, stall, got);
   endtask

   task automatic test_reset_values();
      word_t got;
      int    err0;
      err0 = errors;
      check_bit("uop_ready", uop_ready, 1'b1);
      check_bit("res_valid", res_valid, 1'b0);
      run_uop(alu_uop(OP_MOV, 1'b0, 4'd14, PSW_REG), 0, got);
      check_word("psw_reset", got, 16'hF8FF);
      // select 15 first, before it serves as destination
      for (int s = 15; s >= 0; s--)
      begin
         if (s != 8 && s != 14)
         begin
            run_uop(alu_uop(OP_MOV, 1'b0, 4'd15, reg_sel_t'(s)), 0, got);
            check_word("reg_reset", got, 16'hFFFF);
         end
      end
      end_test("reset values", err0);
   endtask

   task automatic test_random_alu();
      word_t got;
      int    err0;
      err0 = errors;
      for (int r = 0; r < 16; r++)
      begin
         if (r != 6 && r != 8 && r != 12 && r != 13)
            run_uop(ldi_uop(reg_sel_t'(r), 7'($urandom)), 0, got);
      end
      for (int i = 0; i < N_ALU; i++)
         random_op(0);
      end_test("random alu", err0);
   endtask

   task automatic test_sp_banking();
      mode_t      modes [4];
      word_t      sp_val [4];
      logic [6:0] imm;
      word_t      got;
      int         err0;
      err0  = errors;
      modes = '{2'b00, 2'b01, 2'b11, 2'b10};
      for (int m = 0; m < 4; m++)
      begin
         set_psw({modes[m], 10'b0, 4'($urandom)});
         imm       = 7'($urandom);
         sp_val[m] = (modes[m] == 2'b10) ? 16'h0000 : {9'b0, imm};
         run_uop(ldi_uop(SP_REG, imm), 0, got);
         run_uop(alu_uop(OP_MOV, 1'b0, 4'd15, SP_REG), 0, got);
         check_word("sp_readback", got, sp_val[m]);
      end
      // each bank kept its own value
      for (int m = 0; m < 4; m++)
      begin
         set_psw({modes[m], 10'b0, 4'($urandom)});
         run_uop(alu_uop(OP_MOV, 1'b0, 4'd15, SP_REG), 0, got);
         check_word("sp_bank", got, sp_val[m]);
      end
      end_test("stack pointer banking", err0);
   endtask

   task automatic test_ir_fields();
      word_t      irv;
      logic [6:0] imm;
      word_t      got;
      int         err0;
      err0 = errors;
      for (int i = 0; i < N_IR; i++)
      begin
         irv = word_t'($urandom);
         load_word(4'd14, 4'd15, irv);
         run_uop(alu_uop(OP_LDIR, 1'b0, 4'd14, 4'd0), 0, got);
         imm = 7'($urandom);
         run_uop(ldi_uop(IR_DST_SEL, imm), 0, got);
         run_uop(alu_uop(OP_MOV, 1'b0, 4'd15, {1'b0, irv[8:6]}), 0, got);
         if (irv[8:6] != 3'd6)
            check_word("ir_dst_field", got, {9'b0, imm});
         imm = 7'($urandom);
         run_uop(ldi_uop(IR_SRC_SEL, imm), 0, got);
         run_uop(alu_uop(OP_MOV, 1'b0, 4'd15, {1'b0, irv[2:0]}), 0, got);
         if (irv[2:0] != 3'd6)
            check_word("ir_src_field", got, {9'b0, imm});
      end
      end_test("ir register fields", err0);
   endtask

   task automatic test_branches();
      word_t got;
      int    err0;
      err0 = errors;
      for (int i = 0; i < N_BR; i++)
      begin
         load_word(4'd14, 4'd15, word_t'($urandom));
         run_uop(alu_uop(OP_LDIR, 1'b0, 4'd14, 4'd0), 0, got);
         set_psw(word_t'($urandom));
         run_uop(alu_uop(OP_BRA, 1'b0, 4'd0, 4'd0), 0, got);
         for (int c = 0; c < 8; c++)
            run_uop({OP_MBR, 1'b0, 3'(c), 8'h00}, 0, got);
      end
      end_test("branch conditions", err0);
   endtask

   task automatic test_stalls();
      int err0;
      err0 = errors;
      for (int i = 0; i < N_STALL; i++)
         random_op($urandom % 6);
      end_test("result back-pressure", err0);
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired, the DUT stopped responding");
      $display("Test failed");
      $finish;
   end

   initial
   begin
      errors    = 0;
      checks    = 0;
      tests_run = 0;
      clk       = 1'b0;
      rst       = 1'b1;
      uop       = '0;
      uop_valid = 1'b0;
      res_ready = 1'b0;
      void'($urandom(2950));
      model_reset();
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      test_reset_values();
      test_random_alu();
      test_sp_banking();
      test_ir_fields();
      test_branches();
      test_stalls();

      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: verilog/dc302_top.sv
/* DC302 data path top: register file, ALU, branch unit
   and commit stage */
`timescale 1ns/1ps

module dc302_top
   import dc302_data_pkg::*;
   import dc302_uop_pkg::*;
(
   input  logic   clk,
   input  logic   rst,
   input  uop_t   uop,
   input  logic   uop_valid,
   output logic   uop_ready,
   output word_t  res_data,
   output flags_t res_flags,
   output logic   res_branch,
   output logic   res_valid,
   input  logic   res_ready
);

   word_t    a_data;
   word_t    b_data;
   word_t    psw;
   word_t    ir;
   logic     uop_fire;
   op_e      exec_op;
   logic     exec_byte;
   cond_e    exec_cond;
   logic     wr_en;
   reg_sel_t wr_sel;
   word_t    wr_data;
   logic     wr_byte;
   logic     psw_wr;
   word_t    psw_next;
   logic     ir_load;
   word_t    alu_data;
   flags_t   alu_flags;
   logic     ubranch;
   logic     ibranch;

   dc302_regfile u_regfile (
      .clk      (clk),
      .rst      (rst),
      .uop      (uop),
      .uop_fire (uop_fire),
      .wr_en    (wr_en),
      .wr_sel   (wr_sel),
      .wr_data  (wr_data),
      .wr_byte  (wr_byte),
      .psw_wr   (psw_wr),
      .psw_next (psw_next),
      .ir_load  (ir_load),
      .a_data   (a_data),
      .b_data   (b_data),
      .psw      (psw),
      .ir       (ir)
   );

   dc302_alu u_alu (
      .clk       (clk),
      .rst       (rst),
      .op        (exec_op),
      .byte_op   (exec_byte),
      .a_data    (a_data),
      .b_data    (b_data),
      .psw       (psw),
      .alu_data  (alu_data),
      .alu_flags (alu_flags)
   );

   dc302_branch_eval u_branch (
      .clk     (clk),
      .rst     (rst),
      .cond    (exec_cond),
      .psw     (psw),
      .ir      (ir),
      .ubranch (ubranch),
      .ibranch (ibranch)
   );

   dc302_commit u_commit (
      .clk        (clk),
      .rst        (rst),
      .uop        (uop),
      .uop_valid  (uop_valid),
      .uop_ready  (uop_ready),
      .uop_fire   (uop_fire),
      .alu_data   (alu_data),
      .alu_flags  (alu_flags),
      .ubranch    (ubranch),
      .ibranch    (ibranch),
      .psw        (psw),
      .a_data     (a_data),
      .exec_op    (exec_op),
      .exec_byte  (exec_byte),
      .exec_cond  (exec_cond),
      .wr_en      (wr_en),
      .wr_sel     (wr_sel),
      .wr_data    (wr_data),
      .wr_byte    (wr_byte),
      .psw_wr     (psw_wr),
      .psw_next   (psw_next),
      .ir_load    (ir_load),
      .res_data   (res_data),
      .res_flags  (res_flags),
      .res_branch (res_branch),
      .res_valid  (res_valid),
      .res_ready  (res_ready)
   );

endmodule

// File: verilog/dc302_commit.sv
/* sequencing FSM, write-back and PSW flag merge,
   result selection and output handshake */
`timescale 1ns/1ps

module dc302_commit
   import dc302_data_pkg::*;
   import dc302_uop_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  uop_t     uop,
   input  logic     uop_valid,
   output logic     uop_ready,
   output logic     uop_fire,
   input  word_t    alu_data,
   input  flags_t   alu_flags,
   input  logic     ubranch,
   input  logic     ibranch,
   input  word_t    psw,
   input  word_t    a_data,
   output op_e      exec_op,
   output logic     exec_byte,
   output cond_e    exec_cond,
   output logic     wr_en,
   output reg_sel_t wr_sel,
   output word_t    wr_data,
   output logic     wr_byte,
   output logic     psw_wr,
   output word_t    psw_next,
   output logic     ir_load,
   output word_t    res_data,
   output flags_t   res_flags,
   output logic     res_branch,
   output logic     res_valid,
   input  logic     res_ready
);

   state_e state;
   uop_t   uop_q;                                    // microinstruction in flight
   logic   wb_pend;                                  // first cycle of ST_DONE
   logic   writes_reg;
   logic   dest_psw;
   word_t  merged;
   word_t  psw_commit;

   assign uop_ready = (state == ST_IDLE);
   assign uop_fire  = uop_valid && uop_ready;

   assign exec_op   = uop_op(uop_q);
   assign exec_byte = uop_q[UOP_BYTE];
   assign exec_cond = uop_cond(uop_q);

   assign writes_reg = exec_op inside {OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_BIC,
                                       OP_BIS, OP_XOR, OP_ASR, OP_LDI};
   assign dest_psw   = writes_reg && (uop_a_sel(uop_q) == PSW_REG);

   // destination is A, so its high byte survives a byte op
   assign merged = exec_byte ? {a_data[15:8], alu_data[7:0]} : alu_data;

   assign psw_next   = dest_psw ? merged : {psw[15:4], alu_flags};
   assign psw_commit = writes_reg ? (psw_next & PSW_ZERO_MASK) : psw;

   assign wr_sel  = uop_a_sel(uop_q);
   assign wr_data = alu_data;
   assign wr_byte = exec_byte;
   assign wr_en   = wb_pend && writes_reg && !dest_psw;
   assign psw_wr  = wb_pend && writes_reg;           // full PSW when it is the target
   assign ir_load = wb_pend && (exec_op == OP_LDIR);

   assign res_data   = writes_reg ? merged : a_data;
   assign res_flags  = flags_t'(psw_commit[PSW_N:PSW_C]);
   assign res_branch = (exec_op == OP_BRA) ? ibranch :
                       (exec_op == OP_MBR) ? ubranch : 1'b0;
   assign res_valid  = (state == ST_DONE);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= ST_IDLE;
         wb_pend <= 1'b0;
      end
      else
      begin
         wb_pend <= (state == ST_EXEC);
         case (state)
            ST_IDLE: if (uop_valid) state <= ST_EXEC;
            ST_EXEC: state <= ST_DONE;               // operands in ALU
            ST_DONE: if (res_ready) state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (uop_fire)
         uop_q <= uop;
   end

   // back-pressure keeps the result steady until taken
   a_res_hold: assert property (@(posedge clk) disable iff (rst)
      res_valid && !res_ready |=> res_valid && $stable({res_data, res_flags, res_branch}));

endmodule

// File: verilog/dc302_branch_eval.sv
/* microbranch condition and PDP instruction branch rule,
   registered alongside the ALU result */
`timescale 1ns/1ps

module dc302_branch_eval
   import dc302_data_pkg::*;
   import dc302_uop_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   input  cond_e cond,
   input  word_t psw,
   input  word_t ir,
   output logic  ubranch,
   output logic  ibranch
);

   logic n, z, v, c;
   logic u_next;
   logic hit;
   logic i_next;

   assign n = psw[PSW_N];
   assign z = psw[PSW_Z];
   assign v = psw[PSW_V];
   assign c = psw[PSW_C];

   always_comb
   begin
      case (cond)
         C_N:     u_next = n;
         C_Z:     u_next = z;
         C_C:     u_next = c;
         C_V:     u_next = v;
         C_NV:    u_next = n ^ v;
         C_ZNV:   u_next = z | (n ^ v);
         C_CZ:    u_next = c | z;
         default: u_next = (psw_mode(psw) == MODE_KERN);
      endcase
   end

   // PDP branch group from IR bits 15, 10, 9
   always_comb
   begin
      case ({ir[15], ir[10], ir[9]})
         3'b000:  hit = 1'b1;                        // br
         3'b001:  hit = z;                           // beq/bne
         3'b010:  hit = n ^ v;                       // blt/bge
         3'b011:  hit = z | (n ^ v);                 // ble/bgt
         3'b100:  hit = n;                           // bmi/bpl
         3'b101:  hit = c | z;                       // blos/bhi
         3'b110:  hit = v;                           // bvs/bvc
         default: hit = c;                           // bcs/bcc
      endcase
   end

   assign i_next = ir[8] ? hit : ~hit;               // bit 8 selects sense

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ubranch <= 1'b0;
         ibranch <= 1'b0;
      end
      else
      begin
         ubranch <= u_next;
         ibranch <= i_next;
      end
   end

endmodule

// File: alu/dc302_alu.sv
/* registered 16-bit ALU: generate/propagate with nibble look-ahead
   carry, logic ops, arithmetic shift, word and byte flags */
`timescale 1ns/1ps

module dc302_alu
   import dc302_data_pkg::*;
   import dc302_uop_pkg::*;
(
   input  logic   clk,
   input  logic   rst,
   input  op_e    op,
   input  logic   byte_op,
   input  word_t  a_data,
   input  word_t  b_data,
   input  word_t  psw,
   output word_t  alu_data,
   output flags_t alu_flags
);

   logic        sub;
   word_t       y;
   word_t       g;
   word_t       p;
   logic [16:0] c;                                   // carry into each bit
   word_t       sum;
   word_t       res;
   byte_t       res_lo;
   logic        cout, ovf;
   logic        n, z, v, cf;

   assign sub  = (op == OP_SUB);
   assign y    = sub ? ~b_data : b_data;             // a - b as a + ~b + 1
   assign g    = a_data & y;
   assign p    = a_data ^ y;
   assign c[0] = sub;

   // look-ahead carry, one group per nibble
   for (genvar k = 0; k < 16; k += 4)
   begin : g_cla
      assign c[k+1] = g[k]
                    | p[k] & c[k];
      assign c[k+2] = g[k+1]
                    | p[k+1] & g[k]
                    | p[k+1] & p[k] & c[k];
      assign c[k+3] = g[k+2]
                    | p[k+2] & g[k+1]
                    | p[k+2] & p[k+1] & g[k]
                    | p[k+2] & p[k+1] & p[k] & c[k];
      assign c[k+4] = g[k+3]
                    | p[k+3] & g[k+2]
                    | p[k+3] & p[k+2] & g[k+1]
                    | p[k+3] & p[k+2] & p[k+1] & g[k]
                    | p[k+3] & p[k+2] & p[k+1] & p[k] & c[k];
   end

   assign sum  = p ^ c[15:0];
   assign cout = byte_op ? c[8] : c[16];
   assign ovf  = byte_op ? (c[8] ^ c[7]) : (c[16] ^ c[15]);

   always_comb
   begin
      case (op)
         OP_ADD,
         OP_SUB:  res = sum;
         OP_AND:  res = a_data & b_data;
         OP_BIC:  res = a_data & ~b_data;
         OP_BIS:  res = a_data | b_data;
         OP_XOR:  res = a_data ^ b_data;
         OP_ASR:  res = byte_op ? {b_data[15:8], b_data[7], b_data[7:1]}
                                : {b_data[15], b_data[15:1]};
         default: res = b_data;                      // mov, ldi
      endcase
   end

   assign res_lo = res[7:0];
   assign n      = byte_op ? res[7] : res[15];
   assign z      = byte_op ? (res_lo == '0) : (res == '0);

   always_comb
   begin
      case (op)
         OP_ADD:
         begin
            cf = cout;
            v  = ovf;
         end
         OP_SUB:
         begin
            cf = ~cout;                              // borrow
            v  = ovf;
         end
         OP_ASR:
         begin
            cf = b_data[0];
            v  = n ^ b_data[0];
         end
         default:
         begin
            cf = psw[PSW_C];                         // carry kept
            v  = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      alu_data <= res;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         alu_flags <= '0;
      else
         alu_flags <= {n, z, v, cf};
   end

   // look-ahead network agrees with a plain 17-bit add
   a_cla_sum: assert property (@(posedge clk) disable iff (rst)
      !$isunknown({op, a_data, b_data})
         |-> {c[16], sum} == {1'b0, a_data} + {1'b0, y} + 17'(sub));

endmodule

// File: regfile/dc302_regfile.sv
/* sixteen-word register file with mode-banked stack pointer,
   IR field remapping of selects 12/13, and the instruction register */
`timescale 1ns/1ps

module dc302_regfile
   import dc302_data_pkg::*;
   import dc302_uop_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  uop_t     uop,
   input  logic     uop_fire,
   input  logic     wr_en,
   input  reg_sel_t wr_sel,
   input  word_t    wr_data,
   input  logic     wr_byte,
   input  logic     psw_wr,
   input  word_t    psw_next,
   input  logic     ir_load,
   output word_t    a_data,
   output word_t    b_data,
   output word_t    psw,
   output word_t    ir
);

   word_t    regs [16];
   word_t    ir_q;
   mode_t    mode;
   reg_sel_t a_idx, b_idx, w_idx;
   logic     a_ok, b_ok, w_ok;
   word_t    w_val;

   // select to physical register, top bit clear when nothing is addressed
   function automatic logic [4:0] map_sel(input reg_sel_t sel, input mode_t md,
                                          input word_t irv);
      logic [4:0] res;
      res = {1'b1, sel};
      if (sel == IR_DST_SEL)
      begin
         res = {2'b10, irv[8:6]};
      end
      else if (sel == IR_SRC_SEL)
      begin
         res = {2'b10, irv[2:0]};
      end
      else if (sel == SP_REG)
      begin
         case (md)
            MODE_KERN:  res = {1'b1, SP_REG};
            MODE_SUPER: res = {1'b1, SP_SUPER_REG};
            MODE_USER:  res = {1'b1, SP_USER_REG};
            default:    res = {1'b0, SP_REG};        // invalid mode, no stack
         endcase
      end
      return res;
   endfunction

   assign mode           = psw_mode(regs[PSW_REG]);
   assign {a_ok, a_idx}  = map_sel(uop_a_sel(uop), mode, ir_q);
   assign {b_ok, b_idx}  = map_sel(uop_b_sel(uop), mode, ir_q);
   assign {w_ok, w_idx}  = map_sel(wr_sel, mode, ir_q);
   assign w_val          = wr_byte ? {regs[w_idx][15:8], wr_data[7:0]} : wr_data;

   assign psw = regs[PSW_REG];
   assign ir  = ir_q;

   // operand capture on acceptance
   always_ff @(posedge clk)
   begin
      if (uop_fire)
      begin
         a_data <= a_ok ? regs[a_idx] : '0;
         if (uop_op(uop) == OP_LDI)
            b_data <= uop_imm(uop);
         else
            b_data <= b_ok ? regs[b_idx] : '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < 16; i++)
            regs[i] <= REG_RESET;
         regs[PSW_REG] <= PSW_RESET;
         ir_q          <= '0;
      end
      else
      begin
         if (wr_en && w_ok)
         begin
            if (w_idx == PSW_REG)
               regs[PSW_REG] <= w_val & PSW_ZERO_MASK;
            else
               regs[w_idx] <= w_val;
         end
         if (psw_wr)
            regs[PSW_REG] <= psw_next & PSW_ZERO_MASK;   // flags or full PSW
         if (ir_load)
            ir_q <= a_data;
      end
   end

   // commit must never let a register write and a PSW update hit register 8 together
   a_psw_single_writer: assert property (@(posedge clk) disable iff (rst)
      psw_wr |-> !(wr_en && w_ok && (w_idx == PSW_REG)));

endmodule

// File: common/dc302_uop_pkg.sv
/* microinstruction layout, opcode and condition enums,
   sequencing states and field extraction helpers */
package dc302_uop_pkg;

   import dc302_data_pkg::*;

   typedef logic [15:0] uop_t;

   localparam int UOP_OP_HI   = 15;
   localparam int UOP_OP_LO   = 12;
   localparam int UOP_BYTE    = 11;
   localparam int UOP_COND_HI = 10;
   localparam int UOP_COND_LO = 8;
   localparam int UOP_A_HI    = 7;
   localparam int UOP_A_LO    = 4;
   localparam int UOP_B_HI    = 3;
   localparam int UOP_B_LO    = 0;

   typedef enum logic [3:0] {
      OP_MOV  = 4'h0,
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_AND  = 4'h3,
      OP_BIC  = 4'h4,
      OP_BIS  = 4'h5,
      OP_XOR  = 4'h6,
      OP_ASR  = 4'h7,
      OP_LDI  = 4'h8,
      OP_LDIR = 4'h9,
      OP_BRA  = 4'hA,
      OP_MBR  = 4'hB                                 // C..F do nothing
   } op_e;

   typedef enum logic [2:0] {
      C_N    = 3'd0,
      C_Z    = 3'd1,
      C_C    = 3'd2,
      C_V    = 3'd3,
      C_NV   = 3'd4,                                 // N xor V
      C_ZNV  = 3'd5,                                 // Z or (N xor V)
      C_CZ   = 3'd6,
      C_KERN = 3'd7                                  // kernel mode
   } cond_e;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_EXEC,
      ST_DONE
   } state_e;

   function automatic op_e uop_op(input uop_t u);
      return op_e'(u[UOP_OP_HI:UOP_OP_LO]);
   endfunction

   function automatic cond_e uop_cond(input uop_t u);
      return cond_e'(u[UOP_COND_HI:UOP_COND_LO]);
   endfunction

   function automatic reg_sel_t uop_a_sel(input uop_t u);
      return reg_sel_t'(u[UOP_A_HI:UOP_A_LO]);
   endfunction

   function automatic reg_sel_t uop_b_sel(input uop_t u);
      return reg_sel_t'(u[UOP_B_HI:UOP_B_LO]);
   endfunction

   // 7-bit immediate for LDI, zero extended
   function automatic word_t uop_imm(input uop_t u);
      return word_t'({9'b0, u[UOP_COND_HI:UOP_COND_LO], u[UOP_B_HI:UOP_B_LO]});
   endfunction

endpackage

// File: common/dc302_data_pkg.sv
/* data path types: word, byte, register select, mode, flags
   register map, reset values and PSW field layout */
package dc302_data_pkg;

   typedef logic [15:0] word_t;
   typedef logic [7:0]  byte_t;
   typedef logic [3:0]  reg_sel_t;
   typedef logic [1:0]  mode_t;
   typedef logic [3:0]  flags_t;                     // N Z V C, high to low

   localparam reg_sel_t PSW_REG      = 4'd8;
   localparam reg_sel_t SP_REG       = 4'd6;          // kernel stack pointer
   localparam reg_sel_t SP_SUPER_REG = 4'd12;
   localparam reg_sel_t SP_USER_REG  = 4'd13;
   localparam reg_sel_t IR_DST_SEL   = 4'd12;         // selects IR bits 8:6
   localparam reg_sel_t IR_SRC_SEL   = 4'd13;         // selects IR bits 2:0

   localparam word_t REG_RESET     = 16'hFFFF;
   localparam word_t PSW_RESET     = 16'hF8FF;        // user mode, all flags set
   localparam word_t PSW_ZERO_MASK = 16'hF8FF;        // bits 10:8 read as zero

   localparam int PSW_MODE_HI = 15;
   localparam int PSW_MODE_LO = 14;
   localparam int PSW_N       = 3;
   localparam int PSW_Z       = 2;
   localparam int PSW_V       = 1;
   localparam int PSW_C       = 0;

   localparam mode_t MODE_KERN  = 2'b00;
   localparam mode_t MODE_SUPER = 2'b01;
   localparam mode_t MODE_USER  = 2'b11;             // 10 is invalid

   // current processor mode from a PSW value
   function automatic mode_t psw_mode(input word_t w);
      return mode_t'(w[PSW_MODE_HI:PSW_MODE_LO]);
   endfunction

endpackage
